// ==== design/dc2_pkg.sv ====
// --------------------------------------------------
// Shared types for the L2 data cache tag array.
// Tag entry, request, per-way result and response
// words, plus the opcode enum. Modules pull these in
// with a wildcard import in their header.
// --------------------------------------------------
`default_nettype none

package dc2_pkg;

  localparam int DC2_SETS = 256;
  localparam int DC2_TAG_W = 28;

  // Physical line address with the tag in [35:8] and the set in [7:0]
  typedef logic [35:0] dc2_line_t;

  typedef struct packed {
    logic [DC2_TAG_W-1:0] tag;
    logic                 valid;
    logic                 excl;
    logic                 ins_dirty;
  } dc2_tag_entry_t;

  typedef enum logic [1:0] {
    op_lookup  = 2'd0,
    op_fill    = 2'd1,
    op_expunge = 2'd2
  } dc2_op_e;

  typedef struct packed {
    dc2_op_e   op;
    logic      odd;
    logic      split;
    logic      wrt_en;
    logic      excl;
    logic      ins_dirty;
    dc2_line_t line_e;
    dc2_line_t line_o;
  } dc2_req_t;

  // Stage-two result of one way
  typedef struct packed {
    logic           hit_e;
    logic           hit_o;
    logic           valid_p;
    dc2_tag_entry_t entry_p;
    dc2_line_t      line_p;
  } dc2_way_rsp_t;

  typedef struct packed {
    logic      valid;
    logic      hit;
    logic [7:0] hit_way;
    logic      excl;
    logic      ins_dirty;
    logic      evict_valid;
    dc2_line_t evict_line;
  } dc2_rsp_t;

endpackage

`default_nettype wire

// ==== design/dc2_tag_ram.sv ====
// --------------------------------------------------
// Tag RAM of one bank of one way, 256 entries.
// Read address is registered, data follows one cycle
// later. Writes land on the same edge, so a read of
// the same set in the next cycle sees the new word.
// --------------------------------------------------
`default_nettype none

module dc2_tag_ram import dc2_pkg::*; (
  input  logic           clk,
  input  logic           rst,
  input  logic           read_en,
  input  logic [7:0]     read_addr,
  output dc2_tag_entry_t read_data,
  input  logic           write_en,
  input  logic [7:0]     write_addr,
  input  dc2_tag_entry_t write_data
);

  dc2_tag_entry_t mem [DC2_SETS];
  logic [7:0]     read_addr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      read_addr_q <= '0;
    end else if (read_en) begin
      read_addr_q <= read_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[write_addr] <= write_data;
    end
  end

  // Read at the registered address sees writes from the same edge
  assign read_data = mem[read_addr_q];

endmodule

`default_nettype wire

// ==== design/dc2_lfsr.sv ====
// --------------------------------------------------
// Free-running 16-bit Fibonacci LFSR.
// The low 5 bits feed the fill victim choice.
// --------------------------------------------------
`default_nettype none

module dc2_lfsr (
  input  logic       clk,
  input  logic       rst,
  output logic [4:0] rnd
);

  localparam logic [15:0] SEED = 16'hace1;

  logic [15:0] state;
  logic        feedback;

  // Taps of the maximal-length x^16 + x^15 + x^13 + x^4 + 1
  assign feedback = state[15] ^ state[14] ^ state[12] ^ state[3];

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= SEED;
    end else begin
      state <= {state[14:0], feedback};
    end
  end

  assign rnd = state[4:0];

  lfsr_nonzero: assert property (@(posedge clk) disable iff (rst) state != '0);

endmodule

`default_nettype wire

// ==== design/dc2_tag_way.sv ====
// --------------------------------------------------
// One way of the tag array: even and odd tag RAMs,
// stage-two request copy, tag compare and the write
// back of fills, expunges and dirty marks. Results go
// to the control block, which merges all ways.
// --------------------------------------------------
`default_nettype none

module dc2_tag_way import dc2_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         req_en,
  input  dc2_req_t     req,
  input  logic         init_busy,
  input  logic [7:0]   init_index,
  input  logic         fill_sel,
  output dc2_way_rsp_t way_rsp
);

  logic           req_en_q;
  dc2_req_t       req_q;

  dc2_tag_entry_t rd_e;
  dc2_tag_entry_t rd_o;
  dc2_tag_entry_t entry_p;
  dc2_line_t      line_req_p;

  logic [DC2_TAG_W-1:0] tag_e;
  logic [DC2_TAG_W-1:0] tag_o;
  logic           hit_e;
  logic           hit_o;
  logic           hit_p;

  dc2_tag_entry_t upd_data;
  logic           upd_en;
  logic [7:0]     wr_addr;
  dc2_tag_entry_t wr_data;
  logic           wr_en_e;
  logic           wr_en_o;

  // Stage-two copy of the request
  always_ff @(posedge clk) begin
    if (rst) begin
      req_en_q <= 1'b0;
    end else begin
      req_en_q <= req_en;
    end
  end

  always_ff @(posedge clk) begin
    if (req_en) begin
      req_q <= req;
    end
  end

  dc2_tag_ram ram_e (
    .clk        (clk),
    .rst        (rst),
    .read_en    (req_en),
    .read_addr  (req.line_e[7:0]),
    .read_data  (rd_e),
    .write_en   (wr_en_e),
    .write_addr (wr_addr),
    .write_data (wr_data)
  );

  dc2_tag_ram ram_o (
    .clk        (clk),
    .rst        (rst),
    .read_en    (req_en),
    .read_addr  (req.line_o[7:0]),
    .read_data  (rd_o),
    .write_en   (wr_en_o),
    .write_addr (wr_addr),
    .write_data (wr_data)
  );

  // Tag compare per bank
  assign tag_e = req_q.line_e[35:8];
  assign tag_o = req_q.line_o[35:8];
  assign hit_e = req_en_q && rd_e.valid && (rd_e.tag == tag_e);
  assign hit_o = req_en_q && rd_o.valid && (rd_o.tag == tag_o);

  // Primary bank selection
  assign entry_p    = req_q.odd ? rd_o : rd_e;
  assign line_req_p = req_q.odd ? req_q.line_o : req_q.line_e;
  assign hit_p      = req_q.odd ? hit_o : hit_e;

  // Entry update for the primary bank
  always_comb begin
    upd_data = entry_p;
    upd_en   = 1'b0;
    if (fill_sel) begin
      upd_data.tag       = line_req_p[35:8];
      upd_data.valid     = 1'b1;
      upd_data.excl      = req_q.excl;
      upd_data.ins_dirty = req_q.ins_dirty;
      upd_en             = 1'b1;
    end else if (hit_p && req_q.op == op_expunge) begin
      upd_data.valid = 1'b0;
      upd_en         = 1'b1;
    end else if (hit_p && req_q.op == op_lookup && req_q.wrt_en) begin
      upd_data.ins_dirty = 1'b1;
      upd_en             = 1'b1;
    end
  end

  // Init sweep clears both banks and overrides any update
  assign wr_addr = init_busy ? init_index : line_req_p[7:0];
  assign wr_data = init_busy ? '0 : upd_data;
  assign wr_en_e = init_busy || (upd_en && !req_q.odd);
  assign wr_en_o = init_busy || (upd_en && req_q.odd);

  always_comb begin
    way_rsp.hit_e   = hit_e;
    way_rsp.hit_o   = hit_o;
    way_rsp.valid_p = entry_p.valid;
    way_rsp.entry_p = entry_p;
    way_rsp.line_p  = {entry_p.tag, line_req_p[7:0]};
  end

  // Control picks a fill victim only for a live stage-two request
  fill_needs_req: assert property (
    @(posedge clk) disable iff (rst) fill_sel |-> req_en_q
  );

endmodule

`default_nettype wire

// ==== design/dc2_tag_ctrl.sv ====
// --------------------------------------------------
// Tag array control: init sweep, merging of way
// results, fill victim choice and the registered
// response. Sits one cycle behind the ways.
// --------------------------------------------------
`default_nettype none

module dc2_tag_ctrl import dc2_pkg::*; #(
  parameter int WAYS = 4
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         init,
  input  logic [4:0]   rnd,
  input  dc2_way_rsp_t way_rsp [WAYS],
  input  logic         req_en,
  input  dc2_req_t     req,
  output logic         init_busy,
  output logic [7:0]   init_index,
  output logic [WAYS-1:0] fill_sel,
  output dc2_rsp_t     rsp
);

  localparam int IDX_W = (WAYS > 1) ? $clog2(WAYS) : 1;

  logic       req_en_q;
  dc2_op_e    op_q;
  logic       odd_q;
  logic       split_q;

  logic [WAYS-1:0] hit_e_vec;
  logic [WAYS-1:0] hit_o_vec;
  logic [WAYS-1:0] prim_hit_vec;
  logic [WAYS-1:0] other_hit_vec;
  logic [WAYS-1:0] inv_vec;

  logic [IDX_W-1:0] hit_idx;
  logic [IDX_W-1:0] inv_idx;
  logic [IDX_W-1:0] rnd_idx;
  logic [IDX_W-1:0] vict;
  logic       prim_any;
  logic       other_any;
  logic       inv_any;
  logic       is_fill;
  dc2_rsp_t   rsp_d;

  // Init sweep clears one set per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      init_busy  <= 1'b1;
      init_index <= '0;
    end else if (init) begin
      init_busy  <= 1'b1;
      init_index <= '0;
    end else if (init_busy) begin
      init_index <= init_index + 8'd1;
      if (init_index == 8'(DC2_SETS - 1)) begin
        init_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      req_en_q <= 1'b0;
    end else begin
      req_en_q <= req_en;
    end
  end

  always_ff @(posedge clk) begin
    if (req_en) begin
      op_q    <= req.op;
      odd_q   <= req.odd;
      split_q <= req.split;
    end
  end

  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      hit_e_vec[w]     = way_rsp[w].hit_e;
      hit_o_vec[w]     = way_rsp[w].hit_o;
      inv_vec[w]       = !way_rsp[w].valid_p;
    end
    prim_hit_vec  = odd_q ? hit_o_vec : hit_e_vec;
    other_hit_vec = odd_q ? hit_e_vec : hit_o_vec;
  end

  // Lowest-numbered hit and invalid ways
  always_comb begin
    hit_idx = '0;
    inv_idx = '0;
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (prim_hit_vec[w]) begin
        hit_idx = IDX_W'(w);
      end
      if (inv_vec[w]) begin
        inv_idx = IDX_W'(w);
      end
    end
  end

  assign prim_any  = |prim_hit_vec;
  assign other_any = |other_hit_vec;
  assign inv_any   = |inv_vec;
  assign rnd_idx   = IDX_W'(rnd % WAYS);
  assign is_fill   = req_en_q && op_q == op_fill;

  // Victim is the duplicate hit, else the first free way, else random
  always_comb begin
    if (prim_any) begin
      vict = hit_idx;
    end else if (inv_any) begin
      vict = inv_idx;
    end else begin
      vict = rnd_idx;
    end
    fill_sel = '0;
    if (is_fill) begin
      fill_sel[vict] = 1'b1;
    end
  end

  always_comb begin
    rsp_d.valid       = req_en_q;
    rsp_d.hit         = prim_any && (op_q != op_lookup || !split_q || other_any);
    rsp_d.hit_way     = is_fill ? 8'(vict) : 8'(hit_idx);
    rsp_d.excl        = prim_any && way_rsp[hit_idx].entry_p.excl;
    rsp_d.ins_dirty   = prim_any && way_rsp[hit_idx].entry_p.ins_dirty;
    rsp_d.evict_valid = is_fill && !prim_any && !inv_any;
    rsp_d.evict_line  = way_rsp[vict].line_p;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp <= '0;
    end else begin
      rsp <= rsp_d;
    end
  end

  one_hit_per_bank: assert property (
    @(posedge clk) disable iff (rst) $onehot0(hit_e_vec) && $onehot0(hit_o_vec)
  );

  no_req_while_busy: assert property (
    @(posedge clk) disable iff (rst) init_busy |-> !req_en
  );

  fill_sel_onehot: assert property (
    @(posedge clk) disable iff (rst) $onehot0(fill_sel)
  );

endmodule

`default_nettype wire

// ==== design/dc2_tag_top.sv ====
// --------------------------------------------------
// Top of the L2 data cache tag array.
// WAYS ways, each with even and odd banks, merged by
// the control block. Requests are plain strobes and
// must stay low while busy is high.
// --------------------------------------------------
`default_nettype none

module dc2_tag_top import dc2_pkg::*; #(
  parameter int WAYS = 4
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     req_en,
  input  dc2_req_t req,
  input  logic     init,
  output logic     busy,
  output dc2_rsp_t rsp
);

  logic            init_busy;
  logic [7:0]      init_index;
  logic [WAYS-1:0] fill_sel;
  logic [4:0]      rnd;
  dc2_way_rsp_t    way_rsp [WAYS];

  dc2_lfsr u_lfsr (
    .clk (clk),
    .rst (rst),
    .rnd (rnd)
  );

  for (genvar w = 0; w < WAYS; w++) begin : g_way
    dc2_tag_way u_way (
      .clk        (clk),
      .rst        (rst),
      .req_en     (req_en),
      .req        (req),
      .init_busy  (init_busy),
      .init_index (init_index),
      .fill_sel   (fill_sel[w]),
      .way_rsp    (way_rsp[w])
    );
  end

  dc2_tag_ctrl #(
    .WAYS (WAYS)
  ) u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .init       (init),
    .rnd        (rnd),
    .way_rsp    (way_rsp),
    .req_en     (req_en),
    .req        (req),
    .init_busy  (init_busy),
    .init_index (init_index),
    .fill_sel   (fill_sel),
    .rsp        (rsp)
  );

  assign busy = init_busy;

endmodule

`default_nettype wire

// ==== sim/tb_dc2_tag.sv ====
// --------------------------------------------------
// Testbench for the L2 tag array top with 4 ways.
// Keeps a per-set, per-way model of both banks and
// checks every response with concurrent assertions.
// --------------------------------------------------
`default_nettype none

module tb_dc2_tag import dc2_pkg::*; ();

  typedef struct packed {
    logic       hit;
    logic [7:0] way;
    logic       excl;
    logic       dirty;
    logic       evict;
    logic       full;
    logic [7:0] set;
    logic       bank;
  } exp_t;

  logic     clk;
  logic     rst;
  logic     req_en;
  dc2_req_t req;
  logic     init;
  logic     busy;
  dc2_rsp_t rsp;

  dc2_tag_entry_t mdl [2][256][4];
  exp_t           exp_q [$];
  exp_t           cur;
  logic           have_cur;
  dc2_rsp_t       last_rsp;
  int             issued;
  int             rcvd;
  int             errs;
  int             errs_start;
  int             pass_cnt;
  int             fail_cnt;
  logic           pend_full;
  dc2_tag_entry_t pend_entry;
  logic [7:0]     pend_set;
  logic           pend_bank;
  dc2_line_t      lines [4];

  dc2_tag_top #(.WAYS(4)) i_dc2_tag_top (
    .clk    (clk),
    .rst    (rst),
    .req_en (req_en),
    .req    (req),
    .init   (init),
    .busy   (busy),
    .rsp    (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic int find_way(logic b, dc2_line_t l);
    for (int w = 0; w < 4; w++) begin
      if (mdl[b][l[7:0]][w].valid && mdl[b][l[7:0]][w].tag == l[35:8]) return w;
    end
    return -1;
  endfunction

  function automatic int free_way(logic b, logic [7:0] s);
    for (int w = 0; w < 4; w++) begin
      if (!mdl[b][s][w].valid) return w;
    end
    return -1;
  endfunction

  function automatic logic line_in_set(dc2_line_t l, logic b, logic [7:0] s);
    return l[7:0] == s && find_way(b, l) >= 0;
  endfunction

  function automatic dc2_req_t mk_req(dc2_op_e op, logic odd, logic split, logic wrt,
                                      logic ex, logic dty, dc2_line_t le, dc2_line_t lo);
    dc2_req_t r;
    r.op = op;
    r.odd = odd;
    r.split = split;
    r.wrt_en = wrt;
    r.excl = ex;
    r.ins_dirty = dty;
    r.line_e = le;
    r.line_o = lo;
    return r;
  endfunction

  function automatic dc2_line_t mk_line(logic [7:0] s, logic [27:0] t);
    return {t, s};
  endfunction

  task automatic clear_model();
    for (int b = 0; b < 2; b++)
      for (int s = 0; s < 256; s++)
        for (int w = 0; w < 4; w++)
          mdl[b][s][w] = '0;
  endtask

  task automatic mismatch(string name, logic [63:0] got, logic [63:0] want);
    $display("MISMATCH %s got %h expected %h", name, got, want);
    errs++;
  endtask

  task automatic abort(string why);
    $display("%s", why);
    $display("TEST FAIL");
    $finish;
  endtask

  // Update the model and queue the expected response
  task automatic send(dc2_req_t r);
    exp_t           e;
    int             hw;
    int             ow;
    int             fw;
    logic           b;
    dc2_line_t      lp;
    dc2_line_t      lq;
    dc2_tag_entry_t ne;
    b = r.odd;
    lp = b ? r.line_o : r.line_e;
    lq = b ? r.line_e : r.line_o;
    hw = find_way(b, lp);
    ow = find_way(!b, lq);
    e = '0;
    e.set = lp[7:0];
    e.bank = b;
    ne = '{tag: lp[35:8], valid: 1'b1, excl: r.excl, ins_dirty: r.ins_dirty};
    if (hw >= 0) begin
      e.way = 8'(hw);
      e.excl = mdl[b][e.set][hw].excl;
      e.dirty = mdl[b][e.set][hw].ins_dirty;
    end
    e.hit = hw >= 0;
    if (r.op == op_lookup) begin
      e.hit = hw >= 0 && (!r.split || ow >= 0);
      if (hw >= 0 && r.wrt_en) mdl[b][e.set][hw].ins_dirty = 1'b1;
    end else if (r.op == op_expunge) begin
      if (hw >= 0) mdl[b][e.set][hw].valid = 1'b0;
    end else if (hw >= 0) begin
      mdl[b][e.set][hw] = ne;
    end else begin
      fw = free_way(b, e.set);
      if (fw >= 0) begin
        e.way = 8'(fw);
        mdl[b][e.set][fw] = ne;
      end else begin
        e.full = 1'b1;
        e.evict = 1'b1;
        pend_full = 1'b1;
        pend_entry = ne;
        pend_set = e.set;
        pend_bank = b;
      end
    end
    @(posedge clk);
    req_en <= 1'b1;
    req <= r;
    exp_q.push_back(e);
    issued++;
  endtask

  task automatic drain();
    int n;
    @(posedge clk);
    req_en <= 1'b0;
    n = 0;
    while (rcvd != issued) begin
      @(negedge clk);
      n++;
      if (n > 20) abort("no response within 20 cycles of a request");
    end
    // Victim of a full-set fill is only known from the response
    if (pend_full) begin
      @(negedge clk);
      mdl[pend_bank][pend_set][last_rsp.hit_way[1:0]] = pend_entry;
      pend_full = 1'b0;
    end
  endtask

  task automatic txn(dc2_req_t r);
    send(r);
    drain();
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (busy) begin
      n++;
      if (n > 1000) abort("busy did not fall within 1000 cycles");
      @(negedge clk);
    end
    if (n != 256) begin
      $display("busy was high for %0d cycles instead of 256", n);
      errs++;
    end
  endtask

  task automatic end_test(string name);
    @(negedge clk);
    if (errs == errs_start) begin
      pass_cnt++;
      $display("%s: ok", name);
    end else begin
      fail_cnt++;
      $display("%s: FAILED", name);
    end
    errs_start = errs;
  endtask

  always @(negedge clk) begin
    if (rsp.valid) begin
      have_cur = exp_q.size() > 0;
      if (have_cur) cur = exp_q.pop_front();
      last_rsp = rsp;
      rcvd++;
    end
  end

  chk_expected: assert property (@(posedge clk) rsp.valid |-> have_cur)
    else begin
      $display("response arrived with no request outstanding");
      errs++;
    end
  chk_hit: assert property (@(posedge clk) rsp.valid |-> rsp.hit == cur.hit)
    else mismatch("rsp.hit", $sampled(rsp.hit), $sampled(cur.hit));
  chk_way: assert property (@(posedge clk) rsp.valid |->
                            (cur.full ? rsp.hit_way == 8'(find_way(cur.bank, rsp.evict_line))
                                      : rsp.hit_way == cur.way))
    else mismatch("rsp.hit_way", $sampled(rsp.hit_way),
                  cur.full ? 8'(find_way(cur.bank, rsp.evict_line)) : cur.way);
  chk_excl: assert property (@(posedge clk) rsp.valid |-> rsp.excl == cur.excl)
    else mismatch("rsp.excl", $sampled(rsp.excl), $sampled(cur.excl));
  chk_dirty: assert property (@(posedge clk) rsp.valid |-> rsp.ins_dirty == cur.dirty)
    else mismatch("rsp.ins_dirty", $sampled(rsp.ins_dirty), $sampled(cur.dirty));
  chk_evict: assert property (@(posedge clk) rsp.valid |-> rsp.evict_valid == cur.evict)
    else mismatch("rsp.evict_valid", $sampled(rsp.evict_valid), $sampled(cur.evict));
  chk_evict_line: assert property (@(posedge clk) rsp.valid && cur.evict |->
                                   line_in_set(rsp.evict_line, cur.bank, cur.set))
    else mismatch("rsp.evict_line", $sampled(rsp.evict_line), $sampled(cur.set));

  initial begin
    dc2_req_t  r;
    dc2_line_t la;
    dc2_line_t lb;
    int        w;
    void'($urandom(83));
    rst = 1'b1;
    req_en = 1'b0;
    req = '0;
    init = 1'b0;
    have_cur = 1'b0;
    cur = '0;
    last_rsp = '0;
    pend_full = 1'b0;
    issued = 0;
    rcvd = 0;
    errs = 0;
    errs_start = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    clear_model();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);

    wait_ready();
    for (int i = 0; i < 8; i++) begin
      la = mk_line(8'($urandom), 28'($urandom));
      txn(mk_req(op_lookup, 1'($urandom), 1'b0, 1'b0, 1'b0, 1'b0, la, la + 1));
    end
    end_test("reset sweep and misses");

    for (int i = 0; i < 4; i++) begin
      lines[i] = mk_line(8'h10, 28'($urandom));
      txn(mk_req(op_fill, 1'b0, 1'b0, 1'b0, i[0], i[1], lines[i], '0));
    end
    for (int i = 0; i < 4; i++) txn(mk_req(op_lookup, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, lines[i], '0));
    end_test("fills into free ways");

    la = mk_line(8'h20, 28'h1234567);
    txn(mk_req(op_fill, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, la, '0));
    // Store then load to the same set on consecutive cycles
    send(mk_req(op_lookup, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, la, '0));
    send(mk_req(op_lookup, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, la, '0));
    drain();
    end_test("store marks dirty");

    lb = mk_line(8'h10, 28'($urandom));
    txn(mk_req(op_fill, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, lb, '0));
    for (int i = 0; i < 4; i++) txn(mk_req(op_lookup, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, lines[i], '0));
    txn(mk_req(op_lookup, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, lb, '0));
    end_test("eviction from full set");

    txn(mk_req(op_expunge, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, lb, '0));
    txn(mk_req(op_lookup, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, lb, '0));
    w = (find_way(1'b0, lines[0]) >= 0) ? 0 : 1;
    // Refill with the opposite excl of the surviving line
    txn(mk_req(op_fill, 1'b0, 1'b0, 1'b0, w == 0, 1'b0, lines[w], '0));
    txn(mk_req(op_lookup, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, lines[w], '0));
    end_test("expunge and duplicate fill");

    la = mk_line(8'h30, 28'h0abcdef);
    lb = mk_line(8'h31, 28'h0fedcba);
    txn(mk_req(op_fill, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, la, '0));
    txn(mk_req(op_lookup, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, la, lb));
    txn(mk_req(op_fill, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, '0, lb));
    txn(mk_req(op_lookup, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, la, lb));
    txn(mk_req(op_lookup, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, la, lb));
    // Small tag pool over 8 sets so hits, fills and evictions all occur
    for (int i = 0; i < 300; i++) begin
      r.op = dc2_op_e'($urandom_range(0, 2));
      r.odd = 1'($urandom);
      r.wrt_en = 1'($urandom);
      r.split = (r.op == op_lookup && !r.wrt_en) ? 1'($urandom) : 1'b0;
      r.excl = 1'($urandom);
      r.ins_dirty = 1'($urandom);
      r.line_e = mk_line(8'h40 + 8'($urandom_range(0, 7)), 28'($urandom_range(1, 6)));
      r.line_o = mk_line(8'h40 + 8'($urandom_range(0, 7)), 28'($urandom_range(1, 6)));
      txn(r);
    end
    end_test("split lookups and random mix");

    @(posedge clk);
    init <= 1'b1;
    @(posedge clk);
    init <= 1'b0;
    clear_model();
    @(negedge clk);
    wait_ready();
    for (int i = 0; i < 4; i++) txn(mk_req(op_lookup, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, lines[i], '0));
    end_test("init pulse clears tags");

    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
design/dc2_pkg.sv
design/dc2_tag_ram.sv
design/dc2_lfsr.sv
design/dc2_tag_way.sv
design/dc2_tag_ctrl.sv
design/dc2_tag_top.sv
sim/tb_dc2_tag.sv
